// ==== src/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// lane count of one vector instruction
`define LSU_LANES 4

// memory word and byte address width
`define LSU_DATA_W 32

// vector register file address width
`define LSU_VREG_AW 10

// wavefront id, carried as memory tag
`define LSU_WFID_W 6

// unsigned lane offset
`define LSU_IMM_W 16

// known opcodes, everything else is ignored at issue
`define LSU_OPC_LOAD 32'h0000_1001
`define LSU_OPC_STORE 32'h0000_1002

`endif

// ==== src/lsu_pkg.sv ====
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

   // one lane value, address or data
   typedef logic [`LSU_DATA_W-1:0] lane_word_t;

   // one bit per lane
   typedef logic [`LSU_LANES-1:0] lane_mask_t;

   // what the memory port needs for one lane
   typedef struct packed {
      lane_word_t addr;
      lane_word_t data;
   } lane_req_t;

   // all lanes packed, lane 0 in the low word
   typedef logic [`LSU_LANES*`LSU_DATA_W-1:0] lane_vec_t;

endpackage

`default_nettype wire

// ==== src/lsu_op_if.sv ====
`default_nettype none

`include "lsu_settings.svh"

interface lsu_op_if
   import lsu_pkg::*;
();

   // one-cycle pulse when an instruction is accepted
   logic start;
   logic is_load;
   logic [`LSU_WFID_W-1:0] wfid;
   logic [`LSU_VREG_AW-1:0] dest_addr;
   lane_mask_t exec_mask;

   // instruction in flight, back from the controller
   logic busy;

   modport issue (
      output start, is_load, wfid, dest_addr, exec_mask,
      input busy
   );

   modport ctrl (
      input start, is_load, wfid, exec_mask,
      output busy
   );

   modport wb (
      input is_load, wfid, dest_addr, exec_mask
   );

endinterface

`default_nettype wire

// ==== src/lsu_issue_stage.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_issue_stage
   import lsu_pkg::*;
(
   input wire logic clk,
   input wire logic rst,
   input wire logic issue_select_i,
   input wire logic [31:0] issue_opcode_i,
   input wire logic [`LSU_WFID_W-1:0] issue_wfid_i,
   input wire logic [`LSU_VREG_AW-1:0] issue_dest_reg_i,
   input wire logic [`LSU_IMM_W-1:0] issue_imm_i,
   input wire lane_mask_t issue_exec_i,
   input wire lane_vec_t issue_base_i,
   input wire lane_vec_t issue_store_i,
   output logic issue_ready_o,
   output lane_req_t [`LSU_LANES-1:0] reqs_o,
   lsu_op_if.issue op
);

   localparam int unsigned ZEXT_W = `LSU_DATA_W - `LSU_IMM_W;

   logic is_ld_op;
   logic is_st_op;
   logic accept;
   lane_word_t imm_ext;

   assign is_ld_op = (issue_opcode_i == `LSU_OPC_LOAD);
   assign is_st_op = (issue_opcode_i == `LSU_OPC_STORE);

   // frozen from acceptance until the controller lets go
   assign issue_ready_o = ~(op.busy | op.start);
   assign accept = issue_select_i & issue_ready_o & (is_ld_op | is_st_op);

   assign imm_ext = {{ZEXT_W{1'b0}}, issue_imm_i};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op.start <= 1'b0;
      end else begin
         op.start <= accept;
      end
   end

   // fields and lane requests stay put until the next accept
   always_ff @(posedge clk) begin
      if (accept) begin
         op.is_load <= is_ld_op;
         op.wfid <= issue_wfid_i;
         op.dest_addr <= issue_dest_reg_i;
         op.exec_mask <= issue_exec_i;
         for (int l = 0; l < `LSU_LANES; l++) begin
            reqs_o[l].addr <= issue_base_i[l*`LSU_DATA_W +: `LSU_DATA_W] + imm_ext;
            reqs_o[l].data <= issue_store_i[l*`LSU_DATA_W +: `LSU_DATA_W];
         end
      end
   end

   // busy comes from the controller
   a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
      op.start |-> !op.busy);

endmodule

`default_nettype wire

// ==== src/lsu_lane_shifter.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_lane_shifter #(
   parameter type payload_t = logic [31:0]
) (
   input wire logic clk,
   input wire logic rst,
   input wire logic load_i,
   input wire payload_t [`LSU_LANES-1:0] load_val_i,
   input wire logic shift_i,
   input wire payload_t shift_in_i,
   output payload_t head_o,
   output payload_t [`LSU_LANES-1:0] all_o
);

   payload_t [`LSU_LANES-1:0] buf_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         buf_q <= '0;
      end else if (load_i) begin
         buf_q <= load_val_i;
      end else if (shift_i) begin
         // everything moves toward lane 0, new value enters on top
         for (int l = 0; l < `LSU_LANES - 1; l++) begin
            buf_q[l] <= buf_q[l+1];
         end
         buf_q[`LSU_LANES-1] <= shift_in_i;
      end
   end

   // current lane always sits at the bottom
   assign head_o = buf_q[0];
   assign all_o = buf_q;

endmodule

`default_nettype wire

// ==== src/lsu_mem_ctrl.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_mem_ctrl
   import lsu_pkg::*;
(
   input wire logic clk,
   input wire logic rst,
   lsu_op_if.ctrl op,
   input wire lane_req_t head_i,
   input wire logic lsu_stall_i,
   input wire logic mem_ack_i,
   output logic mem_rd_en_o,
   output logic mem_wr_en_o,
   output lane_word_t mem_addr_o,
   output lane_word_t mem_wr_data_o,
   output logic [`LSU_WFID_W-1:0] mem_tag_o,
   output logic step_o,
   output logic last_o
);

   localparam int unsigned CNT_W = (`LSU_LANES > 1) ? $clog2(`LSU_LANES) : 1;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT,
      ST_NEXT
   } state_t;

   state_t state_q;
   state_t state_d;
   logic [CNT_W-1:0] lane_q;
   logic lane_on;
   logic at_last;
   logic req_fire;

   assign lane_on = op.exec_mask[lane_q];
   assign at_last = (lane_q == CNT_W'(`LSU_LANES - 1));

   // a stalled request is simply retried next cycle
   assign req_fire = (state_q == ST_REQ) && lane_on && !lsu_stall_i;

   // inactive lane steps at once and active lane steps on its ack
   assign step_o = ((state_q == ST_REQ) && !lane_on) || ((state_q == ST_WAIT) && mem_ack_i);
   assign last_o = step_o && at_last;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (op.start) begin
               state_d = ST_REQ;
            end
         end
         ST_REQ, ST_WAIT: begin
            if (step_o) begin
               state_d = at_last ? ST_NEXT : ST_REQ;
            end else if (req_fire) begin
               state_d = ST_WAIT;
            end
         end
         // holds busy through the done cycle
         ST_NEXT: state_d = ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
         lane_q <= '0;
      end else begin
         state_q <= state_d;
         if (op.start) begin
            lane_q <= '0;
         end else if (step_o) begin
            lane_q <= lane_q + CNT_W'(1);
         end
      end
   end

   assign op.busy = (state_q != ST_IDLE);

   assign mem_rd_en_o = req_fire && op.is_load;
   assign mem_wr_en_o = req_fire && !op.is_load;
   assign mem_addr_o = head_i.addr;
   assign mem_wr_data_o = head_i.data;
   assign mem_tag_o = op.wfid;

   a_one_enable: assert property (@(posedge clk) disable iff (rst)
      !(mem_rd_en_o && mem_wr_en_o));

   // memory must only answer an outstanding request
   a_ack_in_wait: assert property (@(posedge clk) disable iff (rst)
      mem_ack_i |-> (state_q == ST_WAIT));

endmodule

`default_nettype wire

// ==== src/lsu_writeback.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_writeback
   import lsu_pkg::*;
(
   input wire logic clk,
   input wire logic rst,
   lsu_op_if.wb op,
   input wire logic last_i,
   input wire lane_vec_t gathered_i,
   output logic vgpr_wr_en_o,
   output logic [`LSU_VREG_AW-1:0] vgpr_wr_addr_o,
   output lane_vec_t vgpr_wr_data_o,
   output lane_mask_t vgpr_wr_mask_o,
   output logic instr_done_o,
   output logic [`LSU_WFID_W-1:0] instr_done_wfid_o
);

   // strobes one cycle after the last lane step
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         instr_done_o <= 1'b0;
         vgpr_wr_en_o <= 1'b0;
      end else begin
         instr_done_o <= last_i;
         vgpr_wr_en_o <= last_i & op.is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (last_i) begin
         instr_done_wfid_o <= op.wfid;
         vgpr_wr_addr_o <= op.dest_addr;
         vgpr_wr_mask_o <= op.exec_mask;
      end
   end

   // gather buffer is complete by the strobe cycle, inactive lanes read as zero
   always_comb begin
      for (int l = 0; l < `LSU_LANES; l++) begin
         vgpr_wr_data_o[l*`LSU_DATA_W +: `LSU_DATA_W] =
            op.exec_mask[l] ? gathered_i[l*`LSU_DATA_W +: `LSU_DATA_W] : '0;
      end
   end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_top
   import lsu_pkg::*;
(
   input wire logic clk,
   input wire logic rst,
   input wire logic issue_select_i,
   input wire logic [31:0] issue_opcode_i,
   input wire logic [`LSU_WFID_W-1:0] issue_wfid_i,
   input wire logic [`LSU_VREG_AW-1:0] issue_dest_reg_i,
   input wire logic [`LSU_IMM_W-1:0] issue_imm_i,
   input wire logic [`LSU_LANES-1:0] issue_exec_i,
   input wire logic [`LSU_LANES*`LSU_DATA_W-1:0] issue_base_i,
   input wire logic [`LSU_LANES*`LSU_DATA_W-1:0] issue_store_i,
   output logic issue_ready_o,
   input wire logic lsu_stall_i,
   output logic mem_rd_en_o,
   output logic mem_wr_en_o,
   output logic [`LSU_DATA_W-1:0] mem_addr_o,
   output logic [`LSU_DATA_W-1:0] mem_wr_data_o,
   output logic [`LSU_WFID_W-1:0] mem_tag_o,
   input wire logic mem_ack_i,
   input wire logic [`LSU_DATA_W-1:0] mem_rd_data_i,
   output logic vgpr_wr_en_o,
   output logic [`LSU_VREG_AW-1:0] vgpr_wr_addr_o,
   output logic [`LSU_LANES*`LSU_DATA_W-1:0] vgpr_wr_data_o,
   output logic [`LSU_LANES-1:0] vgpr_wr_mask_o,
   output logic instr_done_o,
   output logic [`LSU_WFID_W-1:0] instr_done_wfid_o
);

   lane_req_t [`LSU_LANES-1:0] reqs;
   lane_req_t head_req;
   lane_word_t [`LSU_LANES-1:0] gathered;
   logic step;
   logic last;

   lsu_op_if op_if ();

   lsu_issue_stage i_issue (
      .clk(clk), .rst(rst),
      .issue_select_i(issue_select_i), .issue_opcode_i(issue_opcode_i),
      .issue_wfid_i(issue_wfid_i), .issue_dest_reg_i(issue_dest_reg_i),
      .issue_imm_i(issue_imm_i), .issue_exec_i(issue_exec_i),
      .issue_base_i(issue_base_i), .issue_store_i(issue_store_i),
      .issue_ready_o(issue_ready_o), .reqs_o(reqs), .op(op_if.issue)
   );

   // lane requests, consumed one per step
   lsu_lane_shifter #(.payload_t(lane_req_t)) i_req_shift (
      .clk(clk), .rst(rst),
      .load_i(op_if.start), .load_val_i(reqs),
      .shift_i(step), .shift_in_i('0),
      .head_o(head_req), .all_o()
   );

   lsu_mem_ctrl i_ctrl (
      .clk(clk), .rst(rst), .op(op_if.ctrl), .head_i(head_req),
      .lsu_stall_i(lsu_stall_i), .mem_ack_i(mem_ack_i),
      .mem_rd_en_o(mem_rd_en_o), .mem_wr_en_o(mem_wr_en_o),
      .mem_addr_o(mem_addr_o), .mem_wr_data_o(mem_wr_data_o),
      .mem_tag_o(mem_tag_o), .step_o(step), .last_o(last)
   );

   // read data enters on top, lane 0 ends up at the bottom
   lsu_lane_shifter #(.payload_t(lane_word_t)) i_gather_shift (
      .clk(clk), .rst(rst),
      .load_i(op_if.start), .load_val_i('0),
      .shift_i(step), .shift_in_i(mem_rd_data_i),
      .head_o(), .all_o(gathered)
   );

   lsu_writeback i_wb (
      .clk(clk), .rst(rst), .op(op_if.wb), .last_i(last), .gathered_i(gathered),
      .vgpr_wr_en_o(vgpr_wr_en_o), .vgpr_wr_addr_o(vgpr_wr_addr_o),
      .vgpr_wr_data_o(vgpr_wr_data_o), .vgpr_wr_mask_o(vgpr_wr_mask_o),
      .instr_done_o(instr_done_o), .instr_done_wfid_o(instr_done_wfid_o)
   );

endmodule

`default_nettype wire

// ==== dv/lsu_tb.sv ====
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb
   import lsu_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int NUM_ROWS = 7;
   // worst lane is one stall cycle plus the request plus a four cycle ack
   localparam int ROW_CYCLES = 6 * `LSU_LANES + 8;
   localparam int LIMIT_CYCLES = NUM_ROWS * ROW_CYCLES + 40;
   localparam int VAL_W = `LSU_LANES * `LSU_DATA_W;

   typedef logic [VAL_W-1:0] val_t;

   typedef struct packed {
      logic [31:0] opc;
      logic [`LSU_WFID_W-1:0] wfid;
      logic [`LSU_VREG_AW-1:0] dest;
      logic [`LSU_IMM_W-1:0] imm;
      lane_mask_t exec;
      lane_vec_t base;
      lane_vec_t store;
      lane_vec_t exp;
   } row_t;

   typedef struct packed {
      lane_word_t addr;
      lane_word_t data;
      logic is_load;
      logic [`LSU_WFID_W-1:0] wfid;
   } mem_req_t;

   logic clk;
   logic rst;
   logic issue_select_i;
   logic [31:0] issue_opcode_i;
   logic [`LSU_WFID_W-1:0] issue_wfid_i;
   logic [`LSU_VREG_AW-1:0] issue_dest_reg_i;
   logic [`LSU_IMM_W-1:0] issue_imm_i;
   lane_mask_t issue_exec_i;
   lane_vec_t issue_base_i;
   lane_vec_t issue_store_i;
   logic issue_ready_o;
   logic lsu_stall_i;
   logic mem_rd_en_o;
   logic mem_wr_en_o;
   lane_word_t mem_addr_o;
   lane_word_t mem_wr_data_o;
   logic [`LSU_WFID_W-1:0] mem_tag_o;
   logic mem_ack_i;
   lane_word_t mem_rd_data_i;
   logic vgpr_wr_en_o;
   logic [`LSU_VREG_AW-1:0] vgpr_wr_addr_o;
   lane_vec_t vgpr_wr_data_o;
   lane_mask_t vgpr_wr_mask_o;
   logic instr_done_o;
   logic [`LSU_WFID_W-1:0] instr_done_wfid_o;

   logic [31:0] lcg_state = 32'd20899;
   lane_word_t mem [lane_word_t];
   mem_req_t exp_q[$];

   // rows assume four lanes with lane 0 as the rightmost word
   row_t tbl [NUM_ROWS] = '{
      '{`LSU_OPC_STORE, 6'h05, 10'h010, 16'h0010, 4'b1111,
        {32'h0000_010C, 32'h0000_0108, 32'h0000_0104, 32'h0000_0100},
        {32'hDDDD_0003, 32'hCCCC_0002, 32'hBBBB_0001, 32'hAAAA_0000}, '0},
      '{`LSU_OPC_LOAD, 6'h2A, 10'h123, 16'h0010, 4'b1111,
        {32'h0000_010C, 32'h0000_0108, 32'h0000_0104, 32'h0000_0100},
        '0, {32'hDDDD_0003, 32'hCCCC_0002, 32'hBBBB_0001, 32'hAAAA_0000}},
      '{`LSU_OPC_STORE, 6'h11, 10'h000, 16'h0020, 4'b0101,
        {32'h0000_0000, 32'h0000_0104, 32'h0000_0000, 32'h0000_0100},
        {32'hFFFF_FFFF, 32'h1234_5678, 32'hFFFF_FFFF, 32'h8765_4321}, '0},
      // inactive lanes point at stored words but must read as zero
      '{`LSU_OPC_LOAD, 6'h3F, 10'h3FF, 16'h0020, 4'b0101,
        {32'h0000_00F0, 32'h0000_0104, 32'h0000_00F4, 32'h0000_0100},
        '0, {32'h0000_0000, 32'h1234_5678, 32'h0000_0000, 32'h8765_4321}},
      '{`LSU_OPC_LOAD, 6'h01, 10'h200, 16'h0010, 4'b0000,
        {32'h0000_010C, 32'h0000_0108, 32'h0000_0104, 32'h0000_0100}, '0, '0},
      // top immediate bit set so the address must not sign extend
      '{`LSU_OPC_STORE, 6'h1C, 10'h0AA, 16'h8000, 4'b1000,
        {32'h0000_0180, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
        {32'hCAFE_F00D, 32'h1111_1111, 32'h2222_2222, 32'h3333_3333}, '0},
      '{`LSU_OPC_LOAD, 6'h33, 10'h155, 16'h8000, 4'b1000,
        {32'h0000_0180, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
        '0, {32'hCAFE_F00D, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}}
   };

   lsu_top i_lsu_top (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // unwritten words read back as a pattern of their address
   function automatic lane_word_t fill_word(input lane_word_t a);
      return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
   endfunction

   task automatic stop_run();
      $display("Testbench failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string name, input val_t got, input val_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   // memory model and stall source
   // acks come one to four cycles after a request
   initial begin : mem_model
      mem_req_t e;
      logic [31:0] rnd;
      logic pending;
      lane_word_t pend_addr;
      int wait_cnt;
      pending = 1'b0;
      pend_addr = '0;
      wait_cnt = 0;
      lsu_stall_i = 1'b0;
      mem_ack_i = 1'b0;
      mem_rd_data_i = '0;
      forever begin
         @(negedge clk);
         if (!rst && (mem_rd_en_o || mem_wr_en_o)) begin
            if (lsu_stall_i) begin
               $display("ERROR: memory request at %0t while lsu_stall_i is high", $time);
               stop_run();
            end else if (pending) begin
               $display("ERROR: second memory request at %0t before the ack", $time);
               stop_run();
            end else if (exp_q.size() == 0) begin
               $display("ERROR: memory request at %0t that no lane should make", $time);
               stop_run();
            end else begin
               e = exp_q.pop_front();
               check_val("mem_rd_en_o", val_t'(mem_rd_en_o), val_t'(e.is_load));
               check_val("mem_wr_en_o", val_t'(mem_wr_en_o), val_t'(!e.is_load));
               check_val("mem_addr_o", val_t'(mem_addr_o), val_t'(e.addr));
               check_val("mem_tag_o", val_t'(mem_tag_o), val_t'(e.wfid));
               if (!e.is_load) begin
                  check_val("mem_wr_data_o", val_t'(mem_wr_data_o), val_t'(e.data));
                  mem[mem_addr_o] = mem_wr_data_o;
               end
               pending = 1'b1;
               pend_addr = mem_addr_o;
               rnd = lcg_next();
               wait_cnt = 1 + int'(rnd[17:16]);
            end
         end
         @(posedge clk);
         #1;
         mem_ack_i = 1'b0;
         if (pending) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
               mem_ack_i = 1'b1;
               mem_rd_data_i = mem.exists(pend_addr) ? mem[pend_addr] : fill_word(pend_addr);
               pending = 1'b0;
            end
         end
         // no two stall cycles in a row so the lane time stays bounded
         rnd = lcg_next();
         lsu_stall_i = (rnd[18:17] == 2'd0) && !lsu_stall_i;
      end
   end

   task automatic run_row(input int idx);
      row_t r;
      mem_req_t e;
      logic is_ld;
      r = tbl[idx];
      is_ld = (r.opc == `LSU_OPC_LOAD);
      for (int l = 0; l < `LSU_LANES; l++) begin
         if (r.exec[l]) begin
            e.addr = r.base[l*`LSU_DATA_W +: `LSU_DATA_W]
               + {{(`LSU_DATA_W - `LSU_IMM_W){1'b0}}, r.imm};
            e.data = r.store[l*`LSU_DATA_W +: `LSU_DATA_W];
            e.is_load = is_ld;
            e.wfid = r.wfid;
            exp_q.push_back(e);
         end
      end
      @(posedge clk);
      #1;
      issue_select_i = 1'b1;
      issue_opcode_i = r.opc;
      issue_wfid_i = r.wfid;
      issue_dest_reg_i = r.dest;
      issue_imm_i = r.imm;
      issue_exec_i = r.exec;
      issue_base_i = r.base;
      issue_store_i = r.store;
      @(posedge clk);
      #1;
      // select stays high with other fields while the frozen issue drops it
      issue_wfid_i = ~r.wfid;
      issue_base_i = ~r.base;
      issue_exec_i = '1;
      do begin
         @(negedge clk);
         check_val("issue_ready_o", val_t'(issue_ready_o), '0);
      end while (!instr_done_o);
      check_val("lane requests left", val_t'(exp_q.size()), '0);
      check_val("instr_done_wfid_o", val_t'(instr_done_wfid_o), val_t'(r.wfid));
      check_val("vgpr_wr_en_o", val_t'(vgpr_wr_en_o), val_t'(is_ld));
      if (is_ld) begin
         check_val("vgpr_wr_addr_o", val_t'(vgpr_wr_addr_o), val_t'(r.dest));
         check_val("vgpr_wr_mask_o", val_t'(vgpr_wr_mask_o), val_t'(r.exec));
         check_val("vgpr_wr_data_o", val_t'(vgpr_wr_data_o), val_t'(r.exp));
      end
      @(posedge clk);
      #1;
      issue_select_i = 1'b0;
   endtask

   // unknown opcodes must neither freeze issue nor reach memory
   task automatic reject_bad_ops();
      @(posedge clk);
      #1;
      issue_select_i = 1'b1;
      issue_exec_i = '1;
      for (int c = 0; c < 6; c++) begin
         issue_opcode_i = c[0] ? 32'h0000_1003 : 32'hDEAD_BEEF;
         @(negedge clk);
         check_val("issue_ready_o", val_t'(issue_ready_o), val_t'(1'b1));
         check_val("instr_done_o", val_t'(instr_done_o), '0);
         @(posedge clk);
         #1;
      end
      issue_select_i = 1'b0;
      repeat (4) begin
         @(negedge clk);
         check_val("instr_done_o", val_t'(instr_done_o), '0);
      end
   endtask

   initial begin : watchdog
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("ERROR: watchdog expired, the tests did not finish in time");
      stop_run();
   end

   initial begin : main
      rst = 1'b1;
      issue_select_i = 1'b0;
      issue_opcode_i = '0;
      issue_wfid_i = '0;
      issue_dest_reg_i = '0;
      issue_imm_i = '0;
      issue_exec_i = '0;
      issue_base_i = '0;
      issue_store_i = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_val("issue_ready_o", val_t'(issue_ready_o), val_t'(1'b1));
      check_val("mem_rd_en_o", val_t'(mem_rd_en_o), '0);
      check_val("mem_wr_en_o", val_t'(mem_wr_en_o), '0);
      check_val("vgpr_wr_en_o", val_t'(vgpr_wr_en_o), '0);
      check_val("instr_done_o", val_t'(instr_done_o), '0);
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      reject_bad_ops();
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_op_if.sv
src/lsu_issue_stage.sv
src/lsu_lane_shifter.sv
src/lsu_mem_ctrl.sv
src/lsu_writeback.sv
src/lsu_top.sv
dv/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module lsu_tb -f list.f -o lsu_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lsu_sim 2>&1 | tee sim.log
grep -q "Testbench failed" sim.log && exit 1 || grep -q "Testbench passed" sim.log || exit 1
exit 0
